// File: lockstep_pkg.sv
/* Shared offset, widths and payload types of the lockstep checker.
   LOCKSTEP_OFFSET must be 1 or more; the payload structs are compared as whole vectors. */
package lockstep_pkg;

  ////////////////////////////////////////////////////////////
  // Lockstep timing
  ////////////////////////////////////////////////////////////

  // Cycles by which the shadow core trails the main core
  localparam int unsigned LOCKSTEP_OFFSET = 2;

  // Width of the shadow reset counter, never below 1
  localparam int unsigned LOCKSTEP_OFFSET_W =
      (LOCKSTEP_OFFSET > 1) ? $clog2(LOCKSTEP_OFFSET) : 1;

  ////////////////////////////////////////////////////////////
  // Accumulator core
  ////////////////////////////////////////////////////////////

  // Operand and accumulator width
  localparam int unsigned DATA_W = 32;

  typedef enum logic [1:0] {
    OP_CLEAR = 2'b00,
    OP_LOAD  = 2'b01,
    OP_ADD   = 2'b10,
    OP_XOR   = 2'b11
  } acc_op_e;

  // Inputs seen by both cores, delayed for the shadow
  typedef struct packed {
    logic              op_valid;
    acc_op_e           op;
    logic [DATA_W-1:0] operand;
  } core_in_t;

  // Outputs compared between main and shadow
  typedef struct packed {
    logic [DATA_W-1:0] acc;
    logic              acc_valid;
    logic              busy;
  } core_out_t;

endpackage

// File: acc_core.sv
/* Single-cycle accumulator, one op accepted per cycle with no back-pressure.
   ADD wraps modulo 2**DATA_W; the carry out shows up only on overflow_o. */
module acc_core (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  lockstep_pkg::core_in_t  in_i,
  output lockstep_pkg::core_out_t out_o,
  output logic                    overflow_o
);

  import lockstep_pkg::*;

  logic [DATA_W-1:0] acc_d;
  logic [DATA_W-1:0] acc_q;
  logic [DATA_W:0]   add_sum;
  logic              add_carry;
  logic              valid_q;
  logic              overflow_d;
  logic              overflow_q;

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  // One extra bit to catch the carry
  assign add_sum   = {1'b0, acc_q} + {1'b0, in_i.operand};
  assign add_carry = add_sum[DATA_W];

  always_comb begin
    acc_d = acc_q;
    if (in_i.op_valid) begin
      unique case (in_i.op)
        OP_CLEAR: acc_d = '0;
        OP_LOAD:  acc_d = in_i.operand;
        OP_ADD:   acc_d = add_sum[DATA_W-1:0];
        OP_XOR:   acc_d = acc_q ^ in_i.operand;
        default:  acc_d = acc_q;
      endcase
    end
  end

  // Only an add can overflow
  assign overflow_d = in_i.op_valid & (in_i.op == OP_ADD) & add_carry;

  ////////////////////////////////////////////////////////////
  // State
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q      <= '0;
      valid_q    <= 1'b0;
      overflow_q <= 1'b0;
    end else begin
      acc_q      <= acc_d;
      valid_q    <= in_i.op_valid;
      overflow_q <= overflow_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  // Result strobe lasts one cycle per accepted op
  assign out_o.acc       = acc_q;
  assign out_o.acc_valid = valid_q;
  // Busy while a result is being presented
  assign out_o.busy      = valid_q;

  assign overflow_o = overflow_q;

endmodule

// File: lockstep_delay.sv
/* Fixed-latency shift pipeline, DEPTH >= 1, holding DEPTH items in flight.
   No reset: contents are undefined until DEPTH cycles of valid input have passed. */
module lockstep_delay #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = lockstep_pkg::LOCKSTEP_OFFSET
) (
  input  logic     clk_i,
  input  payload_t data_i,
  output payload_t data_o
);

  // Entry 0 is the oldest, entry DEPTH-1 the newest
  payload_t pipe_q [DEPTH];

  always_ff @(posedge clk_i) begin
    for (int unsigned i = 0; i < DEPTH - 1; i++) begin
      pipe_q[i] <= pipe_q[i+1];
    end
    pipe_q[DEPTH-1] <= data_i;
  end

  assign data_o = pipe_q[0];

endmodule

// File: shadow_reset_gen.sv
/* Holds the shadow core in reset for LOCKSTEP_OFFSET cycles after rst_ni rises.
   In scan mode (test_en_i high) scan_rst_ni drives the shadow reset directly. */
module shadow_reset_gen (
  input  logic clk_i,
  input  logic rst_ni,

  input  logic test_en_i,
  input  logic scan_rst_ni,

  output logic rst_shadow_no
);

  import lockstep_pkg::*;

  logic [LOCKSTEP_OFFSET_W-1:0] cnt_d;
  logic [LOCKSTEP_OFFSET_W-1:0] cnt_q;
  logic                         set_d;
  logic                         set_q;

  // Saturates once the last count is reached
  assign set_d = (cnt_q == LOCKSTEP_OFFSET_W'(LOCKSTEP_OFFSET - 1));
  assign cnt_d = set_d ? cnt_q : (cnt_q + LOCKSTEP_OFFSET_W'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
      set_q <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      set_q <= set_d;
    end
  end

  // Scan bypass
  assign rst_shadow_no = test_en_i ? scan_rst_ni : set_q;

endmodule

// File: lockstep_checker.sv
/* Runs a shadow accumulator LOCKSTEP_OFFSET cycles behind an external main core.
   Mismatches are masked until the shadow reset is released; alert_major_o is combinational. */
module lockstep_checker (
  input  logic                              clk_i,
  input  logic                              rst_ni,

  // Main core inputs
  input  logic                              op_valid_i,
  input  lockstep_pkg::acc_op_e             op_i,
  input  logic [lockstep_pkg::DATA_W-1:0]   operand_i,

  // Main core outputs
  input  logic [lockstep_pkg::DATA_W-1:0]   acc_i,
  input  logic                              acc_valid_i,
  input  logic                              busy_i,

  // Scan controls
  input  logic                              test_en_i,
  input  logic                              scan_rst_ni,

  output logic                              alert_major_o,
  output logic                              alert_minor_o
);

  import lockstep_pkg::*;

  ////////////////////////////////////////////////////////////
  // Shadow reset
  ////////////////////////////////////////////////////////////

  logic rst_shadow_n;

  shadow_reset_gen u_rst_gen (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .test_en_i     (test_en_i),
    .scan_rst_ni   (scan_rst_ni),
    .rst_shadow_no (rst_shadow_n)
  );

  ////////////////////////////////////////////////////////////
  // Input delay
  ////////////////////////////////////////////////////////////

  core_in_t main_in;
  core_in_t shadow_in;

  assign main_in.op_valid = op_valid_i;
  assign main_in.op       = op_i;
  assign main_in.operand  = operand_i;

  lockstep_delay #(
    .payload_t (core_in_t),
    .DEPTH     (LOCKSTEP_OFFSET)
  ) u_in_delay (
    .clk_i  (clk_i),
    .data_i (main_in),
    .data_o (shadow_in)
  );

  ////////////////////////////////////////////////////////////
  // Output delay
  ////////////////////////////////////////////////////////////

  core_out_t main_out;
  core_out_t main_out_q;

  assign main_out.acc       = acc_i;
  assign main_out.acc_valid = acc_valid_i;
  assign main_out.busy      = busy_i;

  // Same depth as the inputs so both sides line up
  lockstep_delay #(
    .payload_t (core_out_t),
    .DEPTH     (LOCKSTEP_OFFSET)
  ) u_out_delay (
    .clk_i  (clk_i),
    .data_i (main_out),
    .data_o (main_out_q)
  );

  ////////////////////////////////////////////////////////////
  // Shadow core
  ////////////////////////////////////////////////////////////

  core_out_t shadow_out;
  logic      shadow_overflow;

  acc_core u_shadow_core (
    .clk_i      (clk_i),
    .rst_ni     (rst_shadow_n),
    .in_i       (shadow_in),
    .out_o      (shadow_out),
    .overflow_o (shadow_overflow)
  );

  ////////////////////////////////////////////////////////////
  // Compare
  ////////////////////////////////////////////////////////////

  logic outputs_mismatch;

  // Delay line contents are stale until the shadow leaves reset
  assign outputs_mismatch = rst_shadow_n & (shadow_out != main_out_q);

  assign alert_major_o = outputs_mismatch;
  assign alert_minor_o = shadow_overflow;

endmodule

// File: tb_lockstep_tasks.svh
/* Directed tests, checks and stimulus helpers, included inside tb_lockstep.
   Every task starts and returns on a rising edge. */
`ifndef TB_LOCKSTEP_TASKS_SVH
`define TB_LOCKSTEP_TASKS_SVH

// Fibonacci LFSR, taps 32 22 2 1
logic [31:0] lfsr_state = 32'h20c;

function automatic logic lfsr_step();
  logic fb;
  fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
  lfsr_state = {lfsr_state[30:0], fb};
  return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] value;
  value = '0;
  for (int i = 0; i < n; i++) begin
    value = {value[30:0], lfsr_step()};
  end
  return value;
endfunction

////////////////////////////////////////////////////////////
// Checks
////////////////////////////////////////////////////////////

task automatic check_major(input logic expected);
  if (alert_major !== expected) begin
    $display("ERROR %0t: alert_major_o is %b, expected %b in cycle %0d",
             $time, alert_major, expected, cycle);
    major_errors++;
  end
endtask

task automatic check_minor(input logic expected);
  if (alert_minor !== expected) begin
    $display("ERROR %0t: alert_minor_o is %b, expected %b in cycle %0d",
             $time, alert_minor, expected, cycle);
    minor_errors++;
  end
endtask

task automatic check_count(input string what, input int seen, input int expected);
  if (seen != expected) begin
    $display("ERROR %0t: %s is %0d, expected %0d", $time, what, seen, expected);
    count_errors++;
  end
endtask

// Released OFFSET cycles after the rise, or by scan reset in test mode
function automatic logic shadow_released(input int c);
  if (test_en_log[c]) begin
    return scan_rst_log[c];
  end
  for (int k = 0; k <= OFFSET; k++) begin
    if (c < k || !rst_log[c-k]) begin
      return 1'b0;
    end
  end
  return 1'b1;
endfunction

// Record this cycle and compare alerts against the main-side history
task automatic log_and_check();
  int   c;
  logic exp_major;
  logic exp_minor;
  c = cycle;
  rst_log[c]      = rst_n;
  test_en_log[c]  = test_en;
  scan_rst_log[c] = scan_rst_n;
  bad_out_log[c]  = (main_acc !== model_acc) || (main_acc_valid !== model_valid) ||
                    (main_busy !== model_valid);
  ovf_log[c]      = model_ovf;
  exp_major = 1'b0;
  exp_minor = 1'b0;
  if (c >= OFFSET && shadow_released(c)) begin
    exp_major = bad_out_log[c-OFFSET];
    exp_minor = ovf_log[c-OFFSET];
  end
  check_major(exp_major);
  check_minor(exp_minor);
  if (alert_major === 1'b1) begin
    major_seen++;
  end
  if (alert_minor === 1'b1) begin
    minor_seen++;
  end
endtask

////////////////////////////////////////////////////////////
// Stimulus helpers
////////////////////////////////////////////////////////////

task automatic next_cycle();
  @(negedge clk);
  log_and_check();
  @(posedge clk);
endtask

task automatic idle_cycles(input int n);
  op_valid <= 1'b0;
  repeat (n) next_cycle();
endtask

task automatic issue_op(input acc_op_e kind, input logic [DATA_W-1:0] value);
  op_valid <= 1'b1;
  op       <= kind;
  operand  <= value;
  next_cycle();
  op_valid <= 1'b0;
endtask

// Optionally corrupts the main outputs in the last OFFSET reset cycles
task automatic apply_reset(input logic corrupt_tail);
  rst_n    <= 1'b0;
  op_valid <= 1'b0;
  for (int i = 0; i < RESET_CYCLES; i++) begin
    if (corrupt_tail && i >= RESET_CYCLES - OFFSET) begin
      acc_flip <= rand_bits(DATA_W) | 32'd1;
    end
    next_cycle();
  end
  rst_n    <= 1'b1;
  acc_flip <= '0;
  repeat (OFFSET + 1) next_cycle();
endtask

////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////

task automatic test_matching_run();
  int          major_before;
  logic [31:0] kind;
  major_before = major_seen;
  for (int i = 0; i < NUM_OPS; i++) begin
    kind = rand_bits(2);
    issue_op(acc_op_e'(kind[1:0]), rand_bits(DATA_W));
  end
  idle_cycles(DRAIN);
  check_count("major alert cycles in a matching run", major_seen - major_before, 0);
endtask

task automatic test_corrupt_result();
  int major_before;
  int bit_sel;
  major_before = major_seen;
  issue_op(OP_LOAD, rand_bits(DATA_W));
  bit_sel  = int'(rand_bits(5));
  acc_flip <= DATA_W'(1) << bit_sel;
  next_cycle();
  acc_flip <= '0;
  idle_cycles(DRAIN);
  check_count("major alert cycles after one flipped acc bit", major_seen - major_before, 1);
endtask

task automatic test_dropped_strobe();
  int major_before;
  major_before = major_seen;
  issue_op(OP_XOR, rand_bits(DATA_W));
  // Result cycle of the op just issued
  valid_drop <= 1'b1;
  next_cycle();
  valid_drop <= 1'b0;
  idle_cycles(DRAIN);
  check_count("major alert cycles after a dropped strobe", major_seen - major_before, 1);
endtask

task automatic test_overflow();
  int major_before;
  int minor_before;
  major_before = major_seen;
  minor_before = minor_seen;
  issue_op(OP_LOAD, '1);
  issue_op(OP_ADD, DATA_W'(1));
  idle_cycles(DRAIN);
  check_count("minor alert cycles after an overflowing add", minor_seen - minor_before, 1);
  check_count("major alert cycles after an overflowing add", major_seen - major_before, 0);
endtask

task automatic test_startup_mask();
  int major_before;
  major_before = major_seen;
  // Delayed copies of the bad outputs arrive while the shadow is held
  apply_reset(1'b1);
  idle_cycles(DRAIN);
  check_count("major alert cycles around reset release", major_seen - major_before, 0);
endtask

task automatic test_scan_mode();
  int major_before;
  int minor_before;
  major_before = major_seen;
  minor_before = minor_seen;
  test_en    <= 1'b1;
  scan_rst_n <= 1'b0;
  issue_op(OP_LOAD, '1);
  issue_op(OP_ADD, DATA_W'(5));
  acc_flip   <= rand_bits(DATA_W) | 32'd1;
  valid_drop <= 1'b1;
  next_cycle();
  acc_flip   <= '0;
  valid_drop <= 1'b0;
  idle_cycles(DRAIN);
  check_count("major alert cycles in scan mode", major_seen - major_before, 0);
  check_count("minor alert cycles in scan mode", minor_seen - minor_before, 0);
  // Shadow lost its state, so leave scan mode through a full reset
  test_en    <= 1'b0;
  scan_rst_n <= 1'b1;
  apply_reset(1'b0);
endtask

`endif

// File: tb_lockstep.sv
/* Testbench for lockstep_checker with a behavioural main core driving the checked outputs.
   Inputs change on the rising edge; alerts are sampled on the falling edge. */
module tb_lockstep;

  import lockstep_pkg::*;

  ////////////////////////////////////////////////////////////
  // Run limits
  ////////////////////////////////////////////////////////////

  localparam int OFFSET       = int'(LOCKSTEP_OFFSET);
  localparam int RESET_CYCLES = 8;
  localparam int NUM_OPS      = 40;
  // Idle cycles after a test so delayed alerts still land in it
  localparam int DRAIN        = OFFSET + 3;
  localparam int RESET_TASK   = RESET_CYCLES + OFFSET + 1;
  localparam int TEST_CYCLES  = 3 * RESET_TASK + NUM_OPS + 6 * DRAIN + 10;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  logic              clk;
  logic              rst_n;
  logic              op_valid;
  acc_op_e           op;
  logic [DATA_W-1:0] operand;
  logic [DATA_W-1:0] main_acc;
  logic              main_acc_valid;
  logic              main_busy;
  logic              test_en;
  logic              scan_rst_n;
  logic              alert_major;
  logic              alert_minor;

  // Main core model state
  logic [DATA_W-1:0] model_acc;
  logic              model_valid;
  logic              model_ovf;

  // Fault injection on the main outputs
  logic [DATA_W-1:0] acc_flip;
  logic              valid_drop;

  int cycle = 0;
  int major_errors = 0;
  int minor_errors = 0;
  int count_errors = 0;
  int major_seen = 0;
  int minor_seen = 0;

  // Per-cycle history indexed by cycle number
  bit rst_log      [TIMEOUT_CYCLES+1];
  bit test_en_log  [TIMEOUT_CYCLES+1];
  bit scan_rst_log [TIMEOUT_CYCLES+1];
  bit bad_out_log  [TIMEOUT_CYCLES+1];
  bit ovf_log      [TIMEOUT_CYCLES+1];

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  lockstep_checker lockstep_checker_inst (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .op_valid_i    (op_valid),
    .op_i          (op),
    .operand_i     (operand),
    .acc_i         (main_acc),
    .acc_valid_i   (main_acc_valid),
    .busy_i        (main_busy),
    .test_en_i     (test_en),
    .scan_rst_ni   (scan_rst_n),
    .alert_major_o (alert_major),
    .alert_minor_o (alert_minor)
  );

  ////////////////////////////////////////////////////////////
  // Main core model
  ////////////////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      model_acc   <= '0;
      model_valid <= 1'b0;
      model_ovf   <= 1'b0;
    end else begin
      model_valid <= op_valid;
      model_ovf   <= 1'b0;
      if (op_valid) begin
        case (op)
          OP_CLEAR: model_acc <= '0;
          OP_LOAD:  model_acc <= operand;
          OP_ADD: begin
            model_acc <= model_acc + operand;
            // Carry when the operand exceeds the headroom left in acc
            model_ovf <= (operand > ~model_acc);
          end
          OP_XOR:   model_acc <= model_acc ^ operand;
          default:  model_acc <= model_acc;
        endcase
      end
    end
  end

  assign main_acc       = model_acc ^ acc_flip;
  assign main_acc_valid = model_valid & ~valid_drop;
  assign main_busy      = model_valid;

  // Watchdog
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  `include "tb_lockstep_tasks.svh"

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n      = 1'b0;
    op_valid   = 1'b0;
    op         = OP_CLEAR;
    operand    = '0;
    test_en    = 1'b0;
    scan_rst_n = 1'b1;
    acc_flip   = '0;
    valid_drop = 1'b0;

    @(posedge clk);
    apply_reset(1'b0);

    test_matching_run();
    test_corrupt_result();
    test_dropped_strobe();
    test_overflow();
    test_startup_mask();
    test_scan_mode();

    $display("Errors: %0d on alert_major_o, %0d on alert_minor_o, %0d on pulse counts",
             major_errors, minor_errors, count_errors);
    if (major_errors + minor_errors + count_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+.
lockstep_pkg.sv
acc_core.sv
lockstep_delay.sv
shadow_reset_gen.sv
lockstep_checker.sv
tb_lockstep.sv
